//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_cache_subsys
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- be_arbiter.sv
`timescale 1ns/1ps

module be_arbiter
   import cache_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,

   // cache ports
   input  logic     req0,
   input  mem_req_t data0,
   input  logic     req1,
   input  mem_req_t data1,
   output word_t    rdata,
   output logic     ack0,
   output logic     ack1,

   // ram port
   output logic     ram_req,
   output mem_req_t ram_data,
   input  word_t    ram_rdata,
   input  logic     ram_ack
);

   arb_state_e state;

   // port that owns the current access
   logic grant;
   // port that wins a tie
   logic prio;
   logic pick;

   assign pick = (req0 && req1) ? prio : req1;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= arb_idle;
         grant   <= 1'b0;
         prio    <= 1'b0;
         ram_req <= 1'b0;
      end else begin
         ram_req <= 1'b0;
         case (state)
            arb_idle: begin
               if (req0 || req1) begin
                  grant   <= pick;
                  prio    <= ~pick;
                  ram_req <= 1'b1;
                  state   <= arb_busy;
               end
            end
            arb_busy: begin
               // caches update be_req on this same edge
               if (ram_ack) begin
                  state <= arb_idle;
               end
            end
            default: begin
               state <= arb_idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == arb_idle) begin
         ram_data <= pick ? data1 : data0;
      end
   end

   assign rdata = ram_rdata;
   assign ack0  = ram_ack && !grant;
   assign ack1  = ram_ack && grant;

endmodule

//--- be_ram.sv
`timescale 1ns/1ps

`include "cache_cfg.svh"

module be_ram
   import cache_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     req,
   input  mem_req_t req_data,
   output word_t    rdata,
   output logic     ack
);

   localparam int NWORDS = 1 << `WADDR_W;

   word_t mem [NWORDS];

   // old contents come back on a write as well
   always_ff @(posedge clk) begin
      if (req) begin
         for (int b = 0; b < `DATA_W / 8; b++) begin
            if (req_data.wstrb[b]) begin
               mem[req_data.addr][8*b +: 8] <= req_data.wdata[8*b +: 8];
            end
         end
         rdata <= mem[req_data.addr];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ack <= 1'b0;
      end else begin
         ack <= req;
      end
   end

endmodule

//--- cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// data word on both the front end and the backend
`define DATA_W 32

// word address into the backend memory, 1024 words
`define WADDR_W 10

// cache geometry
// 16 lines per cache
`define NLINES_W 4

// 4 words per line
`define OFFSET_W 2

// whatever is left of the word address above index and offset
`define TAG_W (`WADDR_W - `NLINES_W - `OFFSET_W)

`endif

//--- cache_ctrl.sv
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_ctrl
   import cache_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     invalidate,

   // requester side
   input  logic     req,
   input  mem_req_t req_data,
   output word_t    rdata,
   output logic     ack,

   // backend side, one word per be_req
   output logic     be_req,
   output mem_req_t be_data,
   input  word_t    be_rdata,
   input  logic     be_ack
);

   localparam int NLINES = 1 << `NLINES_W;
   localparam int NWORDS = 1 << `OFFSET_W;

   cache_state_e      state;
   logic [NLINES-1:0] valid;
   tag_t              tag_mem  [NLINES];
   word_t             data_mem [NLINES][NWORDS];

   // word of the line being fetched
   offset_t   fill_cnt;
   offset_t   next_off;
   logic      fill_last;

   tag_t      req_tag;
   line_idx_t req_idx;
   offset_t   req_off;
   logic      is_read;
   logic      hit;
   word_t     merged;

   // request is held steady until ack, so decode it in place
   assign {req_tag, req_idx, req_off} = req_data.addr;
   assign is_read = (req_data.wstrb == '0);
   assign hit = valid[req_idx] && (tag_mem[req_idx] == req_tag);

   assign next_off  = fill_cnt + offset_t'(1);
   assign fill_last = (fill_cnt == offset_t'(NWORDS - 1));

   // cached word with the write bytes laid over it
   always_comb begin
      merged = data_mem[req_idx][req_off];
      for (int b = 0; b < `DATA_W / 8; b++) begin
         if (req_data.wstrb[b]) begin
            merged[8*b +: 8] = req_data.wdata[8*b +: 8];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= cs_idle;
         ack      <= 1'b0;
         be_req   <= 1'b0;
         fill_cnt <= '0;
         valid    <= '0;
      end else begin
         ack <= 1'b0;
         case (state)
            cs_idle: begin
               // req is still high during the ack cycle
               if (req && !ack) begin
                  state <= cs_lookup;
               end
            end
            cs_lookup: begin
               if (!is_read) begin
                  be_req <= 1'b1;
                  state  <= cs_write_thru;
               end else if (hit) begin
                  ack   <= 1'b1;
                  state <= cs_idle;
               end else begin
                  be_req   <= 1'b1;
                  fill_cnt <= '0;
                  state    <= cs_refill;
               end
            end
            cs_refill: begin
               if (be_ack) begin
                  fill_cnt <= next_off;
                  if (fill_last) begin
                     be_req         <= 1'b0;
                     valid[req_idx] <= 1'b1;
                     ack            <= 1'b1;
                     state          <= cs_idle;
                  end
               end
            end
            cs_write_thru: begin
               if (be_ack) begin
                  be_req <= 1'b0;
                  ack    <= 1'b1;
                  state  <= cs_idle;
               end
            end
            default: begin
               state <= cs_idle;
            end
         endcase

         // flash clear wins over a line finishing its refill
         if (invalidate) begin
            valid <= '0;
         end
      end
   end

   // arrays, read data and backend request payload
   always_ff @(posedge clk) begin
      case (state)
         cs_lookup: begin
            rdata <= data_mem[req_idx][req_off];
            if (is_read) begin
               // refill starts at word 0 of the line
               be_data.addr  <= {req_tag, req_idx, offset_t'(0)};
               be_data.wdata <= req_data.wdata;
               be_data.wstrb <= '0;
            end else begin
               be_data <= req_data;
            end
         end
         cs_refill: begin
            if (be_ack) begin
               data_mem[req_idx][fill_cnt] <= be_rdata;
               be_data.addr <= {req_tag, req_idx, next_off};
               if (fill_cnt == req_off) begin
                  rdata <= be_rdata;
               end
               if (fill_last) begin
                  tag_mem[req_idx] <= req_tag;
               end
            end
         end
         cs_write_thru: begin
            // only a write hit touches the line
            if (be_ack && hit) begin
               data_mem[req_idx][req_off] <= merged;
            end
         end
         default: begin
         end
      endcase
   end

endmodule

//--- cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

   typedef logic [`DATA_W-1:0]   word_t;
   typedef logic [`DATA_W/8-1:0] strb_t;
   typedef logic [`WADDR_W-1:0]  waddr_t;

   // address fields, top to bottom
   typedef logic [`TAG_W-1:0]    tag_t;
   typedef logic [`NLINES_W-1:0] line_idx_t;
   typedef logic [`OFFSET_W-1:0] offset_t;

   // one word access; zero wstrb means read
   typedef struct packed {
      waddr_t addr;
      word_t  wdata;
      strb_t  wstrb;
   } mem_req_t;

   typedef enum logic [1:0] {
      cs_idle,
      cs_lookup,
      cs_refill,
      cs_write_thru
   } cache_state_e;

   typedef enum logic {
      arb_idle,
      arb_busy
   } arb_state_e;

endpackage

//--- cache_subsys.sv
`timescale 1ns/1ps

module cache_subsys
   import cache_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     invalidate,

   // port 0
   input  logic     req0,
   input  mem_req_t req_data0,
   output word_t    rdata0,
   output logic     ack0,

   // port 1
   input  logic     req1,
   input  mem_req_t req_data1,
   output word_t    rdata1,
   output logic     ack1
);

   logic     be_req0;
   logic     be_req1;
   mem_req_t be_data0;
   mem_req_t be_data1;
   logic     be_ack0;
   logic     be_ack1;
   word_t    be_rdata;

   logic     ram_req;
   mem_req_t ram_data;
   word_t    ram_rdata;
   logic     ram_ack;

   cache_ctrl cache0_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .invalidate (invalidate),
      .req        (req0),
      .req_data   (req_data0),
      .rdata      (rdata0),
      .ack        (ack0),
      .be_req     (be_req0),
      .be_data    (be_data0),
      .be_rdata   (be_rdata),
      .be_ack     (be_ack0)
   );

   cache_ctrl cache1_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .invalidate (invalidate),
      .req        (req1),
      .req_data   (req_data1),
      .rdata      (rdata1),
      .ack        (ack1),
      .be_req     (be_req1),
      .be_data    (be_data1),
      .be_rdata   (be_rdata),
      .be_ack     (be_ack1)
   );

   be_arbiter arb_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .req0      (be_req0),
      .data0     (be_data0),
      .req1      (be_req1),
      .data1     (be_data1),
      .rdata     (be_rdata),
      .ack0      (be_ack0),
      .ack1      (be_ack1),
      .ram_req   (ram_req),
      .ram_data  (ram_data),
      .ram_rdata (ram_rdata),
      .ram_ack   (ram_ack)
   );

   be_ram ram_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (ram_req),
      .req_data (ram_data),
      .rdata    (ram_rdata),
      .ack      (ram_ack)
   );

endmodule

//--- sources.f
+incdir+.
cache_pkg.sv
cache_ctrl.sv
be_arbiter.sv
be_ram.sv
cache_subsys.sv
tb_cache_subsys.sv

//--- tb_cache_subsys.sv
`timescale 1ns/1ps

`include "cache_cfg.svh"

module tb_cache_subsys
   import cache_pkg::*;
();

   localparam int NLINES    = 1 << `NLINES_W;
   localparam int NWORDS    = 1 << `OFFSET_W;
   localparam int MEM_WORDS = 1 << `WADDR_W;
   // limit for the whole run, well above the length of all tests together
   localparam int MAX_CYCLES = 20000;

   logic     clk;
   logic     rst_n;
   logic     invalidate;
   logic     req0;
   logic     req1;
   mem_req_t req_data0;
   mem_req_t req_data1;
   word_t    rdata0;
   word_t    rdata1;
   logic     ack0;
   logic     ack1;

   // reference memory and one model of cached lines per port
   word_t ref_mem [MEM_WORDS];
   logic  c_valid [2][NLINES];
   tag_t  c_tag   [2][NLINES];
   word_t c_data  [2][NLINES][NWORDS];

   int req_cnt [2] = '{0, 0};
   int ack_cnt [2] = '{0, 0};
   int cycle_cnt = 0;

   cache_subsys dut_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .invalidate (invalidate),
      .req0       (req0),
      .req_data0  (req_data0),
      .rdata0     (rdata0),
      .ack0       (ack0),
      .req1       (req1),
      .req_data1  (req_data1),
      .rdata1     (rdata1),
      .ack1       (ack1)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
         abort_run();
      end
   end

   // every ack pulse, per port
   always @(negedge clk) begin
      if (rst_n) begin
         if (ack0) ack_cnt[0]++;
         if (ack1) ack_cnt[1]++;
      end
   end

   task automatic abort_run();
      $display("Regression failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_ack(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_cycles(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic model_write(input int port, input waddr_t addr, input word_t wdata,
                              input strb_t wstrb);
      tag_t      t;
      line_idx_t i;
      offset_t   o;
      {t, i, o} = addr;
      for (int b = 0; b < `DATA_W / 8; b++) begin
         if (wstrb[b]) begin
            ref_mem[addr][8*b +: 8] = wdata[8*b +: 8];
            // only the writing port's own cache sees the new bytes
            if (c_valid[port][i] && c_tag[port][i] == t) begin
               c_data[port][i][o][8*b +: 8] = wdata[8*b +: 8];
            end
         end
      end
   endtask

   task automatic model_read(input int port, input waddr_t addr, output word_t data,
                             output logic hit);
      tag_t      t;
      line_idx_t i;
      offset_t   o;
      {t, i, o} = addr;
      hit = c_valid[port][i] && (c_tag[port][i] == t);
      if (!hit) begin
         for (int w = 0; w < NWORDS; w++) begin
            c_data[port][i][w] = ref_mem[{t, i, offset_t'(w)}];
         end
         c_valid[port][i] = 1'b1;
         c_tag[port][i]   = t;
      end
      data = c_data[port][i][o];
   endtask

   // one request on a port; lat counts edges from the req sample to the ack
   task automatic access(input int port, input waddr_t addr, input word_t wdata,
                         input strb_t wstrb, output word_t rd, output int lat);
      mem_req_t r;
      logic     a;
      r.addr  = addr;
      r.wdata = wdata;
      r.wstrb = wstrb;
      @(negedge clk);
      if (port == 0) begin
         req0      = 1'b1;
         req_data0 = r;
      end else begin
         req1      = 1'b1;
         req_data1 = r;
      end
      req_cnt[port]++;
      lat = 0;
      a   = 1'b0;
      while (!a) begin
         @(negedge clk);
         a = (port == 0) ? ack0 : ack1;
         if (!a) lat++;
      end
      rd = (port == 0) ? rdata0 : rdata1;
      if (port == 0) begin
         req0      = 1'b0;
         req_data0 = '0;
      end else begin
         req1      = 1'b0;
         req_data1 = '0;
      end
      // ack is a single pulse
      @(negedge clk);
      check_ack(port == 0 ? "ack0" : "ack1", 1'b0, (port == 0) ? ack0 : ack1);
   endtask

   task automatic write_word(input int port, input waddr_t addr, input word_t wdata,
                             input strb_t wstrb);
      word_t rd;
      int    lat;
      access(port, addr, wdata, wstrb, rd, lat);
      model_write(port, addr, wdata, wstrb);
   endtask

   task automatic read_word(input int port, input waddr_t addr, output int lat);
      word_t exp;
      word_t rd;
      logic  hit;
      model_read(port, addr, exp, hit);
      access(port, addr, '0, '0, rd, lat);
      check_word(port == 0 ? "rdata0" : "rdata1", exp, rd);
      if (hit) begin
         check_cycles(port == 0 ? "ack0 hit latency" : "ack1 hit latency", 1, lat);
      end
   endtask

   task automatic fill_line(input int port, input tag_t t, input line_idx_t i);
      for (int w = 0; w < NWORDS; w++) begin
         write_word(port, {t, i, offset_t'(w)}, word_t'($urandom), 4'b1111);
      end
   endtask

   task automatic pulse_invalidate();
      @(negedge clk);
      invalidate = 1'b1;
      @(negedge clk);
      invalidate = 1'b0;
      for (int p = 0; p < 2; p++) begin
         for (int i = 0; i < NLINES; i++) begin
            c_valid[p][i] = 1'b0;
         end
      end
   endtask

   task automatic idle_after_reset();
      repeat (8) begin
         @(negedge clk);
         check_ack("ack0", 1'b0, ack0);
         check_ack("ack1", 1'b0, ack1);
      end
   endtask

   task automatic write_read_one_port();
      waddr_t a;
      int     lat;
      a = {tag_t'($urandom), line_idx_t'(1), offset_t'($urandom)};
      write_word(0, a, word_t'($urandom), 4'b1111);
      read_word(0, a, lat);
      read_word(0, a, lat);
      check_cycles("ack0 hit latency", 1, lat);
   endtask

   task automatic byte_strobes();
      waddr_t a;
      int     lat;
      a = {tag_t'($urandom), line_idx_t'(2), offset_t'($urandom)};
      write_word(0, a, word_t'($urandom), 4'b1111);
      write_word(0, a, word_t'($urandom), 4'b0001);
      write_word(0, a, word_t'($urandom), 4'b0110);
      write_word(0, a, word_t'($urandom), 4'b1000);
      // fresh miss returns the merged word from memory
      read_word(0, a, lat);
      // now cached, so these merge into the line as well
      write_word(0, a, word_t'($urandom), 4'b1010);
      write_word(0, a, word_t'($urandom), 4'b0101);
      write_word(0, a, word_t'($urandom), 4'b0011);
      read_word(0, a, lat);
      check_cycles("ack0 hit latency", 1, lat);
   endtask

   task automatic line_refill();
      tag_t t;
      int   lat;
      t = tag_t'($urandom);
      fill_line(0, t, line_idx_t'(3));
      read_word(0, {t, line_idx_t'(3), offset_t'(2)}, lat);
      for (int w = 0; w < NWORDS; w++) begin
         if (w != 2) begin
            read_word(0, {t, line_idx_t'(3), offset_t'(w)}, lat);
            check_cycles("ack0 hit latency", 1, lat);
         end
      end
   endtask

   task automatic stale_then_invalidate();
      waddr_t a;
      word_t  old_w;
      int     lat;
      a = {tag_t'($urandom), line_idx_t'(5), offset_t'($urandom)};
      fill_line(0, a[`WADDR_W-1 -: `TAG_W], line_idx_t'(5));
      old_w = ref_mem[a];
      read_word(1, a, lat);
      // new value always differs in bit 0
      write_word(0, a, old_w ^ (word_t'($urandom) | word_t'(1)), 4'b1111);
      // port 1 keeps the old word until the flash clear
      read_word(1, a, lat);
      check_cycles("ack1 hit latency", 1, lat);
      pulse_invalidate();
      read_word(1, a, lat);
   endtask

   task automatic contention();
      tag_t t0;
      tag_t t1;
      tag_t t2;
      tag_t t3;
      t0 = tag_t'($urandom);
      t1 = tag_t'($urandom);
      t2 = tag_t'($urandom);
      t3 = tag_t'($urandom);
      fork
         fill_line(0, t0, line_idx_t'(8));
         fill_line(1, t1, line_idx_t'(9));
      join
      // each port reads the line the other one wrote, then writes a new line
      fork
         begin
            int lat;
            for (int w = 0; w < NWORDS; w++) begin
               read_word(0, {t1, line_idx_t'(9), offset_t'(w)}, lat);
            end
            fill_line(0, t2, line_idx_t'(10));
         end
         begin
            int lat;
            for (int w = 0; w < NWORDS; w++) begin
               read_word(1, {t0, line_idx_t'(8), offset_t'(w)}, lat);
            end
            fill_line(1, t3, line_idx_t'(11));
         end
      join
      fork
         begin
            int lat;
            read_word(0, {t3, line_idx_t'(11), offset_t'($urandom)}, lat);
         end
         begin
            int lat;
            read_word(1, {t2, line_idx_t'(10), offset_t'($urandom)}, lat);
         end
      join
      check_cycles("ack0 count", req_cnt[0], ack_cnt[0]);
      check_cycles("ack1 count", req_cnt[1], ack_cnt[1]);
   endtask

   initial begin
      void'($urandom(32'h6cd03e9b));
      for (int p = 0; p < 2; p++) begin
         for (int i = 0; i < NLINES; i++) begin
            c_valid[p][i] = 1'b0;
         end
      end
      rst_n      = 1'b0;
      invalidate = 1'b0;
      req0       = 1'b0;
      req1       = 1'b0;
      req_data0  = '0;
      req_data1  = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      idle_after_reset();
      write_read_one_port();
      byte_strobes();
      line_refill();
      stale_then_invalidate();
      contention();

      $display("Regression passed");
      $finish;
   end

endmodule
